/* rtl/panel_ctrl_pkg.sv */
// Shared types and command encodings for the LED panel command front end.
// Imported by every RTL module of the controller.

package panel_ctrl_pkg;

    // one command or pixel byte
    typedef logic [7:0] byte_t;

    // one plane per bit of the 6-bit green channel
    localparam int BRIGHTNESS_LEVELS = 6;

    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    // colour plane enables
    localparam byte_t CMD_RED_ON    = "R";
    localparam byte_t CMD_RED_OFF   = "r";
    localparam byte_t CMD_GREEN_ON  = "G";
    localparam byte_t CMD_GREEN_OFF = "g";
    localparam byte_t CMD_BLUE_ON   = "B";
    localparam byte_t CMD_BLUE_OFF  = "b";

    // brightness plane controls
    localparam byte_t CMD_PLANES_OFF = "0";
    localparam byte_t CMD_PLANES_ON  = "9";
    // digits 1..6 are offsets from this character
    localparam byte_t CMD_PLANE_BASE = "0";

    // multi-byte commands
    localparam byte_t CMD_LOAD_BRIGHTNESS = "T";
    localparam byte_t CMD_PIXEL           = "P";
    localparam byte_t CMD_BLANK           = "Z";

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHTNESS,
        ST_PIXEL,
        ST_BLANK
    } cmd_state_e;

endpackage

/* rtl/panel_cmd_decoder.sv */
// Command decoder: accepts bytes, runs the command FSM and holds the
// colour and brightness plane enables. Multi-byte commands go to the write engines.

`timescale 1ns/1ps

module panel_cmd_decoder import panel_ctrl_pkg::*; (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        byte_valid,
    input  byte_t       byte_data,
    input  logic        pixel_done,
    input  logic        blank_done,
    output logic        byte_ready,
    output rgb_t        rgb_enable,
    output brightness_t brightness_enable,
    output logic        pixel_byte,
    output byte_t       pixel_data,
    output logic        blank_start
);

    cmd_state_e  state;
    cmd_state_e  state_d;
    rgb_t        rgb_d;
    brightness_t bright_d;

    // accepted byte, decoded in the following cycle
    byte_t       byte_q;
    logic        byte_q_valid;
    logic        accept;
    byte_t       digit;

    assign accept = byte_valid && byte_ready;

    // Z is already being decoded, so hold input off one cycle early
    assign blank_start = byte_q_valid && (state == ST_IDLE) && (byte_q == CMD_BLANK);
    assign byte_ready  = (state != ST_BLANK) && !blank_start;

    assign pixel_byte = byte_q_valid && (state == ST_PIXEL);
    assign pixel_data = byte_q;

    assign digit = byte_q - CMD_PLANE_BASE;

    always_ff @(posedge clk_in) begin
        if (accept) begin
            byte_q <= byte_data;
        end
    end

    always_comb begin
        state_d  = state;
        rgb_d    = rgb_enable;
        bright_d = brightness_enable;
        case (state)
            ST_IDLE: begin
                if (byte_q_valid) begin
                    case (byte_q)
                        CMD_RED_ON:          rgb_d[0] = 1'b1;
                        CMD_RED_OFF:         rgb_d[0] = 1'b0;
                        CMD_GREEN_ON:        rgb_d[1] = 1'b1;
                        CMD_GREEN_OFF:       rgb_d[1] = 1'b0;
                        CMD_BLUE_ON:         rgb_d[2] = 1'b1;
                        CMD_BLUE_OFF:        rgb_d[2] = 1'b0;
                        CMD_PLANES_OFF:      bright_d = '0;
                        CMD_PLANES_ON:       bright_d = '1;
                        CMD_LOAD_BRIGHTNESS: state_d = ST_BRIGHTNESS;
                        CMD_PIXEL:           state_d = ST_PIXEL;
                        CMD_BLANK:           state_d = ST_BLANK;
                        default: begin
                            // digit n toggles plane LEVELS-n, anything else is ignored
                            if (digit >= 8'd1 && digit <= BRIGHTNESS_LEVELS) begin
                                bright_d[BRIGHTNESS_LEVELS - int'(digit)] =
                                    ~brightness_enable[BRIGHTNESS_LEVELS - int'(digit)];
                            end
                        end
                    endcase
                end
            end
            ST_BRIGHTNESS: begin
                if (byte_q_valid) begin
                    bright_d = byte_q[BRIGHTNESS_LEVELS-1:0];
                    state_d  = ST_IDLE;
                end
            end
            ST_PIXEL: begin
                if (pixel_done) begin
                    state_d = ST_IDLE;
                end
            end
            ST_BLANK: begin
                if (blank_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state             <= ST_IDLE;
            byte_q_valid      <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            state             <= state_d;
            byte_q_valid      <= accept;
            rgb_enable        <= rgb_d;
            brightness_enable <= bright_d;
        end
    end

endmodule

/* rtl/pixel_write_cmd.sv */
// Pixel write engine: row, column, then two data bytes.
// The data bytes become writes to byte select 1 and 0 of that pixel.

`timescale 1ns/1ps

module pixel_write_cmd import panel_ctrl_pkg::*; #(
    parameter int ROW_BITS = 5,
    parameter int COL_BITS = 6
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       pixel_byte,
    input  byte_t                      pixel_data,
    output logic                       pixel_done,
    output logic                       pixel_we,
    output logic [ROW_BITS+COL_BITS:0] pixel_addr,
    output byte_t                      pixel_wdata
);

    // which byte of the command comes next
    logic [1:0]          byte_cnt;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            byte_cnt <= 2'd0;
        end else if (pixel_byte) begin
            // wraps back to 0 after the second data byte
            byte_cnt <= byte_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (pixel_byte && byte_cnt == 2'd0) begin
            row_q <= pixel_data[ROW_BITS-1:0];
        end
        if (pixel_byte && byte_cnt == 2'd1) begin
            col_q <= pixel_data[COL_BITS-1:0];
        end
    end

    // bytes 2 and 3 are data; first goes to select 1 (little-endian)
    assign pixel_we    = pixel_byte && byte_cnt[1];
    assign pixel_addr  = {row_q, col_q, ~byte_cnt[0]};
    assign pixel_wdata = pixel_data;

    assign pixel_done = pixel_byte && (byte_cnt == 2'd3);

endmodule

/* rtl/panel_blank_cmd.sv */
// Blank engine: sweeps every frame-buffer address once, writing zero.
// Started by a one-cycle pulse; flags its last write.

`timescale 1ns/1ps

module panel_blank_cmd import panel_ctrl_pkg::*; #(
    parameter int ROW_BITS = 5,
    parameter int COL_BITS = 6
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       blank_start,
    output logic                       blank_done,
    output logic                       blank_we,
    output logic [ROW_BITS+COL_BITS:0] blank_addr,
    output byte_t                      blank_wdata
);

    logic                       running;
    logic [ROW_BITS+COL_BITS:0] addr_q;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            addr_q  <= '0;
        end else if (blank_start) begin
            running <= 1'b1;
            addr_q  <= '0;
        end else if (running) begin
            addr_q <= addr_q + 1'b1;
            // stop after the all-ones address
            if (&addr_q) begin
                running <= 1'b0;
            end
        end
    end

    assign blank_we    = running;
    assign blank_addr  = addr_q;
    assign blank_wdata = '0;
    assign blank_done  = running && (&addr_q);

endmodule

/* rtl/ram_write_port.sv */
// Frame-buffer write port: takes whichever engine is requesting and
// registers it, giving a one-cycle write strobe per byte.

`timescale 1ns/1ps

module ram_write_port import panel_ctrl_pkg::*; #(
    parameter int ADDR_BITS = 12
) (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 pixel_we,
    input  logic [ADDR_BITS-1:0] pixel_addr,
    input  byte_t                pixel_wdata,
    input  logic                 blank_we,
    input  logic [ADDR_BITS-1:0] blank_addr,
    input  byte_t                blank_wdata,
    output logic                 ram_we,
    output logic [ADDR_BITS-1:0] ram_addr,
    output byte_t                ram_wdata
);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= pixel_we || blank_we;
        end
    end

    // engines never overlap, blank just wins the mux
    always_ff @(posedge clk_in) begin
        if (blank_we) begin
            ram_addr  <= blank_addr;
            ram_wdata <= blank_wdata;
        end else if (pixel_we) begin
            ram_addr  <= pixel_addr;
            ram_wdata <= pixel_wdata;
        end
    end

endmodule

/* rtl/panel_ctrl_top.sv */
// Command front end of the RGB LED matrix controller.
// Takes command bytes over a valid/ready handshake and drives the frame-buffer write port.

`timescale 1ns/1ps

module panel_ctrl_top import panel_ctrl_pkg::*; #(
    parameter int ROW_BITS = 5,
    parameter int COL_BITS = 6
) (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       byte_valid,
    input  byte_t                      byte_data,
    output logic                       byte_ready,
    output rgb_t                       rgb_enable,
    output brightness_t                brightness_enable,
    output logic                       ram_we,
    output logic [ROW_BITS+COL_BITS:0] ram_addr,
    output byte_t                      ram_wdata
);

    // row, column, byte select
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + 1;

    logic                 pixel_byte;
    byte_t                pixel_data;
    logic                 pixel_done;
    logic                 pixel_we;
    logic [ADDR_BITS-1:0] pixel_addr;
    byte_t                pixel_wdata;

    logic                 blank_start;
    logic                 blank_done;
    logic                 blank_we;
    logic [ADDR_BITS-1:0] blank_addr;
    byte_t                blank_wdata;

    panel_cmd_decoder i_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .byte_data         (byte_data),
        .pixel_done        (pixel_done),
        .blank_done        (blank_done),
        .byte_ready        (byte_ready),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .pixel_byte        (pixel_byte),
        .pixel_data        (pixel_data),
        .blank_start       (blank_start)
    );

    pixel_write_cmd #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS)
    ) i_pixel (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixel_byte  (pixel_byte),
        .pixel_data  (pixel_data),
        .pixel_done  (pixel_done),
        .pixel_we    (pixel_we),
        .pixel_addr  (pixel_addr),
        .pixel_wdata (pixel_wdata)
    );

    panel_blank_cmd #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS)
    ) i_blank (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .blank_done  (blank_done),
        .blank_we    (blank_we),
        .blank_addr  (blank_addr),
        .blank_wdata (blank_wdata)
    );

    ram_write_port #(
        .ADDR_BITS (ADDR_BITS)
    ) i_ram_port (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixel_we    (pixel_we),
        .pixel_addr  (pixel_addr),
        .pixel_wdata (pixel_wdata),
        .blank_we    (blank_we),
        .blank_addr  (blank_addr),
        .blank_wdata (blank_wdata),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata)
    );

endmodule

/* dv/tb_clk_gen.sv */
// Clock and reset source for the panel controller testbench.
// Reset is held high for the first few rising edges.

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_in = ~clk_in;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;
    end

endmodule

/* dv/tb_panel_ctrl.sv */
// Testbench for the panel command front end: drives command bytes,
// tracks the plane enables with a reference model and shadows the frame buffer.

`timescale 1ns/1ps

module tb_panel_ctrl import panel_ctrl_pkg::*; ();

    localparam int ROW_BITS      = 3;
    localparam int COL_BITS      = 4;
    localparam int ADDR_BITS     = ROW_BITS + COL_BITS + 1;
    localparam int NUM_ADDR      = 1 << ADDR_BITS;
    localparam int PLANES        = 6;
    localparam int READY_TIMEOUT = 1000;

    logic                 clk_in;
    logic                 reset;
    logic                 byte_valid;
    byte_t                byte_data;
    logic                 byte_ready;
    rgb_t                 rgb_enable;
    brightness_t          brightness_enable;
    logic                 ram_we;
    logic [ADDR_BITS-1:0] ram_addr;
    byte_t                ram_wdata;

    int                   errors;
    int                   checks;
    rgb_t                 exp_rgb;
    brightness_t          exp_bright;
    byte_t                shadow [NUM_ADDR];
    byte_t                exp_fb [NUM_ADDR];
    logic [ADDR_BITS-1:0] addr_log [$];
    byte_t                data_log [$];

    // single-byte commands plus 7 and 8, which are not commands
    byte_t cmd_pool [16] = '{"R", "r", "G", "g", "B", "b", "0", "1",
                             "2", "3", "4", "5", "6", "9", "7", "8"};

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (4)
    ) i_clk_gen (
        .clk_in (clk_in),
        .reset  (reset)
    );

    panel_ctrl_top #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS)
    ) i_dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .byte_valid        (byte_valid),
        .byte_data         (byte_data),
        .byte_ready        (byte_ready),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_we            (ram_we),
        .ram_addr          (ram_addr),
        .ram_wdata         (ram_wdata)
    );

    // expected {rgb, planes} after one single-byte command
    function automatic logic [8:0] next_planes(input rgb_t rgb, input brightness_t br,
                                               input byte_t b);
        int          n;
        rgb_t        r_next;
        brightness_t b_next;
        r_next = rgb;
        b_next = br;
        n = int'(b) - 48;
        case (b)
            "R": r_next[0] = 1'b1;
            "r": r_next[0] = 1'b0;
            "G": r_next[1] = 1'b1;
            "g": r_next[1] = 1'b0;
            "B": r_next[2] = 1'b1;
            "b": r_next[2] = 1'b0;
            "0": b_next = '0;
            "9": b_next = '1;
            default: begin
                if (n >= 1 && n <= PLANES) begin
                    b_next[PLANES-n] = ~b_next[PLANES-n];
                end
            end
        endcase
        return {r_next, b_next};
    endfunction

    function automatic byte_t pick_plane_cmd();
        byte_t b;
        if ($urandom % 2 == 0) begin
            b = cmd_pool[$urandom % 16];
        end else begin
            b = byte_t'($urandom);
            // keep multi-byte commands out of this mix
            if (b == "T" || b == "P" || b == "Z") begin
                b = 8'h00;
            end
        end
        return b;
    endfunction

    task automatic send_byte(input byte_t b, output int waited);
        waited = 0;
        @(posedge clk_in);
        byte_valid <= 1'b1;
        byte_data  <= b;
        @(negedge clk_in);
        while (!byte_ready && waited < READY_TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        if (!byte_ready) begin
            errors++;
            $display("timeout: byte_ready stayed low for %0d cycles", waited);
        end
        @(posedge clk_in);
        byte_valid <= 1'b0;
    endtask

    task automatic send_pixel(input byte_t row, input byte_t col, input byte_t d0,
                              input byte_t d1);
        byte_t seq [5];
        int    waited;
        seq = '{"P", row, col, d0, d1};
        for (int i = 0; i < 5; i++) begin
            send_byte(seq[i], waited);
            checks++;
            if (waited != 0) begin
                errors++;
                $display("byte_ready was held low for %0d cycles during a pixel command",
                         waited);
            end
        end
    endtask

    task automatic settle(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    task automatic compare_frame();
        for (int a = 0; a < NUM_ADDR; a++) begin
            checks++;
            if (shadow[a] !== exp_fb[a]) begin
                errors++;
                $display("Fail ram_wdata at ram_addr 0x%02h: got 0x%02h, expected 0x%02h",
                         a, shadow[a], exp_fb[a]);
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        end
    endtask

    // frame-buffer shadow
    always @(negedge clk_in) begin
        if (!reset && ram_we) begin
            shadow[ram_addr] = ram_wdata;
            addr_log.push_back(ram_addr);
            data_log.push_back(ram_wdata);
        end
    end

    // plane enables against the model, every cycle
    always @(negedge clk_in) begin
        if (!reset) begin
            checks++;
            if (rgb_enable !== exp_rgb) begin
                errors++;
                $display("Fail rgb_enable: got 0x%0h, expected 0x%0h", rgb_enable, exp_rgb);
            end
            if (brightness_enable !== exp_bright) begin
                errors++;
                $display("Fail brightness_enable: got 0x%02h, expected 0x%02h",
                         brightness_enable, exp_bright);
            end
        end
    end

    initial begin
        int          errs_before;
        int          waited;
        int          cycles;
        int          a;
        byte_t       b;
        byte_t       row;
        byte_t       col;
        byte_t       d0;
        byte_t       d1;
        logic [8:0]  nxt;
        errors     = 0;
        checks     = 0;
        byte_valid = 1'b0;
        byte_data  = '0;
        exp_rgb    = '1;
        exp_bright = '1;
        void'($urandom(61));
        for (int i = 0; i < NUM_ADDR; i++) begin
            shadow[i] = byte_t'(i) ^ 8'h5a;
            exp_fb[i] = byte_t'(i) ^ 8'h5a;
        end

        cycles = 0;
        while (reset && cycles < 20) begin
            @(negedge clk_in);
            cycles++;
        end
        if (reset) begin
            errors++;
            $display("timeout: reset never released");
        end

        // test 1: reset values
        errs_before = errors;
        @(negedge clk_in);
        checks++;
        if (byte_ready !== 1'b1) begin
            errors++;
            $display("Fail byte_ready: got 0x%0h, expected 0x1", byte_ready);
        end
        settle(4);
        checks++;
        if (ram_we !== 1'b0 || addr_log.size() != 0) begin
            errors++;
            $display("ram_we was raised after reset with no command sent");
        end
        report_test(1, "reset state", errs_before);

        // test 2: colour and plane commands
        errs_before = errors;
        repeat (200) begin
            b = pick_plane_cmd();
            send_byte(b, waited);
            @(posedge clk_in);
            nxt = next_planes(exp_rgb, exp_bright, b);
            exp_rgb    <= nxt[8:6];
            exp_bright <= nxt[5:0];
        end
        settle(2);
        report_test(2, "colour and plane commands", errs_before);

        // test 3: brightness load
        errs_before = errors;
        repeat (10) begin
            b = byte_t'($urandom);
            send_byte("T", waited);
            send_byte(b, waited);
            @(posedge clk_in);
            exp_bright <= b[PLANES-1:0];
        end
        settle(2);
        report_test(3, "brightness load", errs_before);

        // test 4: pixel writes
        errs_before = errors;
        repeat (12) begin
            row = byte_t'($urandom);
            col = byte_t'($urandom);
            d0  = byte_t'($urandom);
            d1  = byte_t'($urandom);
            addr_log.delete();
            data_log.delete();
            send_pixel(row, col, d0, d1);
            a = ((row % (1 << ROW_BITS)) << (COL_BITS + 1)) + ((col % (1 << COL_BITS)) << 1);
            exp_fb[a+1] = d0;
            exp_fb[a]   = d1;
            settle(3);
            checks++;
            if (addr_log.size() != 2) begin
                errors++;
                $display("pixel command made %0d writes instead of 2", addr_log.size());
            end
            compare_frame();
        end
        report_test(4, "pixel writes", errs_before);

        // test 5: blank sweep with a byte offered while it runs
        errs_before = errors;
        for (int i = 0; i < 3; i++) begin
            send_pixel(byte_t'($urandom), byte_t'($urandom), 8'hff, 8'hee);
        end
        settle(3);
        addr_log.delete();
        data_log.delete();
        send_byte("Z", waited);
        @(negedge clk_in);
        checks++;
        if (byte_ready !== 1'b0) begin
            errors++;
            $display("Fail byte_ready: got 0x%0h, expected 0x0", byte_ready);
        end
        // a plane toggle always changes the enables
        send_byte("1", waited);
        checks++;
        if (addr_log.size() != NUM_ADDR) begin
            errors++;
            $display("byte accepted after only %0d of %0d blank writes",
                     addr_log.size(), NUM_ADDR);
        end
        @(posedge clk_in);
        nxt = next_planes(exp_rgb, exp_bright, "1");
        exp_rgb    <= nxt[8:6];
        exp_bright <= nxt[5:0];
        settle(3);
        checks++;
        if (addr_log.size() != NUM_ADDR) begin
            errors++;
            $display("blank made %0d writes instead of %0d", addr_log.size(), NUM_ADDR);
        end
        for (int i = 0; i < addr_log.size(); i++) begin
            checks++;
            if (addr_log[i] !== ADDR_BITS'(i) || data_log[i] !== 8'h00) begin
                errors++;
                $display("Fail ram_addr/ram_wdata %0d: got 0x%02h/0x%02h, expected 0x%02h/0x00",
                         i, addr_log[i], data_log[i], i);
            end
        end
        for (int i = 0; i < NUM_ADDR; i++) begin
            exp_fb[i] = 8'h00;
        end
        compare_frame();
        report_test(5, "panel blank", errs_before);

        settle(2);
        $display("tests done, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/panel_ctrl_pkg.sv
rtl/panel_cmd_decoder.sv
rtl/pixel_write_cmd.sv
rtl/panel_blank_cmd.sv
rtl/ram_write_port.sv
rtl/panel_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_panel_ctrl.sv

/* Bender.yml */
package:
  name: panel_ctrl

sources:
  - rtl/panel_ctrl_pkg.sv
  - rtl/panel_cmd_decoder.sv
  - rtl/pixel_write_cmd.sv
  - rtl/panel_blank_cmd.sv
  - rtl/ram_write_port.sv
  - rtl/panel_ctrl_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_panel_ctrl.sv
